//--- compile.f
verilog/burstPkg.sv
verilog/axiLiteRegs.sv
verilog/stepTimer.sv
verilog/burstSequencer.sv
verilog/triggerBurstTop.sv
sim/triggerBurstTb.sv

//--- sim/triggerBurstTb.sv
// Testbench for the trigger burst sequencer
// Drives the AXI4-Lite port and checks pulse order and spacing against a reference model

`timescale 1ns/1ps

module triggerBurstTb;

    localparam int TIMEOUT = 50;                // Cycles allowed per handshake wait

    logic                        clk;
    logic                        nrst;
    burstPkg::axiLiteReq_t       req;
    burstPkg::axiLiteRsp_t       rsp;
    logic [burstPkg::NUM_CH-1:0] trig;

    int          cycle = 0;                     // Rising edges since time zero
    int          errCount;
    int          errAtStart;
    int          testsPassed;
    int          testsFailed;
    logic [31:0] lcgState;
    logic [7:0]  burstsDone;                    // Expected STATUS count

    // Monitor expectations
    int          expBase;                       // Cycle where busy rises
    int          expWidth;
    int          expIdx;                        // NUM_CH when no pulse is due

    // Last AXI results
    logic [1:0]  lastResp;
    logic [31:0] lastData;
    int          bvalidCycle;                   // Cycle where bvalid was first seen

    triggerBurstTop dut_i (
        .clk  (clk),
        .nrst (nrst),
        .req  (req),
        .rsp  (rsp),
        .trig (trig)
    );

    // 100 ns clock
    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    //----------------------------------------
    // Reference model and checks
    //----------------------------------------
    function automatic logic [31:0] lcgNext(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Offset of channel k's pulse from busy rising
    function automatic int pulseOffset(input int width, input int k);
        return (k + 1) * (width + 1);
    endfunction

    task automatic checkValue(input string name, input logic [31:0] exp,
                              input logic [31:0] act);
        if (act !== exp) begin
            $display("FAILED %s: expected 0x%h, actual 0x%h", name, exp, act);
            errCount++;
        end
    endtask

    task automatic endTest(input string name);
        if (errCount == errAtStart) begin
            testsPassed++;
            $display("Test %s: ok", name);
        end else begin
            testsFailed++;
            $display("Test %s: %0d errors", name, errCount - errAtStart);
        end
    endtask

    // Pulse monitor sampled mid-cycle
    always @(negedge clk) begin
        if (nrst && trig != '0) begin
            if (expIdx >= burstPkg::NUM_CH) begin
                $display("Unexpected trigger pulse 0x%h at cycle %0d", trig, cycle);
                errCount++;
            end else begin
                checkValue($sformatf("trig ch%0d value", expIdx),
                           32'(1) << expIdx, 32'(trig));          // One bit on the right channel
                checkValue($sformatf("trig ch%0d cycle", expIdx),
                           expBase + pulseOffset(expWidth, expIdx), cycle);
                expIdx++;
            end
        end
    end

    //----------------------------------------
    // AXI4-Lite master tasks
    //----------------------------------------
    task automatic axiWrite(input logic [burstPkg::ADDR_W-1:0] addr, input logic [31:0] data);
        int n;
        @(posedge clk);
        #5;
        req.awvalid = 1'b1;
        req.awaddr  = addr;
        req.wvalid  = 1'b1;
        req.wdata   = data;
        req.bready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rsp.awready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rsp.awready) begin
            $display("Timeout waiting for awready on a write to 0x%h", addr);
            errCount++;
        end
        checkValue("wready", 32'h1, 32'(rsp.wready));   // Rises with awready
        @(posedge clk);                         // Write accepted on this edge
        #5;
        req.awvalid = 1'b0;
        req.wvalid  = 1'b0;
        n = 0;
        @(negedge clk);
        while (!rsp.bvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rsp.bvalid) begin
            $display("Timeout waiting for bvalid on a write to 0x%h", addr);
            errCount++;
        end
        bvalidCycle = cycle;
        lastResp    = rsp.bresp;
        @(posedge clk);
        #5;
        req.bready = 1'b0;
    endtask

    task automatic axiRead(input logic [burstPkg::ADDR_W-1:0] addr);
        int n;
        @(posedge clk);
        #5;
        req.arvalid = 1'b1;
        req.araddr  = addr;
        req.rready  = 1'b1;
        n = 0;
        @(negedge clk);
        while (!rsp.arready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rsp.arready) begin
            $display("Timeout waiting for arready on a read of 0x%h", addr);
            errCount++;
        end
        @(posedge clk);
        #5;
        req.arvalid = 1'b0;
        n = 0;
        @(negedge clk);
        while (!rsp.rvalid && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!rsp.rvalid) begin
            $display("Timeout waiting for rvalid on a read of 0x%h", addr);
            errCount++;
        end
        lastData = rsp.rdata;
        lastResp = rsp.rresp;
        @(posedge clk);
        #5;
        req.rready = 1'b0;
    endtask

    //----------------------------------------
    // Burst helpers
    //----------------------------------------
    task automatic startBurst(input int width);
        axiWrite(burstPkg::STEP, 32'(width));
        checkValue("bresp STEP", burstPkg::RESP_OKAY, lastResp);
        axiWrite(burstPkg::CTRL, 32'h1);
        checkValue("bresp CTRL", burstPkg::RESP_OKAY, lastResp);
        expBase  = bvalidCycle + 1;             // Busy rises one edge after start
        expWidth = width;
        expIdx   = 0;
        burstsDone++;
    endtask

    task automatic waitBurstEnd();
        int n;
        int limit;
        n     = 0;
        limit = pulseOffset(expWidth, burstPkg::NUM_CH - 1) + TIMEOUT;
        while (expIdx < burstPkg::NUM_CH && n < limit) begin
            @(negedge clk);
            n++;
        end
        if (expIdx < burstPkg::NUM_CH) begin
            $display("Timeout waiting for the burst, only %0d pulses seen", expIdx);
            errCount++;
            expIdx = burstPkg::NUM_CH;          // Stop expecting pulses
        end
    endtask

    // Expects idle and the model's burst count
    task automatic checkStatus();
        axiRead(burstPkg::STATUS);
        checkValue("rresp STATUS", burstPkg::RESP_OKAY, lastResp);
        checkValue("STATUS", {16'd0, burstsDone, 8'd0}, lastData);
    endtask

    //----------------------------------------
    // Test sequence
    //----------------------------------------
    initial begin
        int width;
        req         = '0;
        nrst        = 1'b0;
        errCount    = 0;
        errAtStart  = 0;
        testsPassed = 0;
        testsFailed = 0;
        lcgState    = 32'h508f_3358;
        burstsDone  = '0;
        expBase     = 0;
        expWidth    = 0;
        expIdx      = burstPkg::NUM_CH;
        repeat (10) @(posedge clk);
        #5;
        nrst = 1'b1;

        // Reset values and STEP readback
        errAtStart = errCount;
        @(negedge clk);
        checkValue("trig", 32'h0, 32'(trig));
        checkStatus();
        axiRead(burstPkg::STEP);
        checkValue("STEP", 32'h0, lastData);
        axiWrite(burstPkg::STEP, 32'h0000_a5c3);
        checkValue("bresp STEP", burstPkg::RESP_OKAY, lastResp);
        axiRead(burstPkg::STEP);
        checkValue("rresp STEP", burstPkg::RESP_OKAY, lastResp);
        checkValue("STEP", 32'h0000_a5c3, lastData);
        endTest("reset and readback");

        // One burst at step 3
        errAtStart = errCount;
        startBurst(3);
        waitBurstEnd();
        checkStatus();
        endTest("single burst");

        // New STEP and a second start while running
        errAtStart = errCount;
        startBurst(6);
        axiRead(burstPkg::STATUS);              // Busy set, count not yet updated
        checkValue("STATUS busy", {16'd0, burstsDone - 8'd1, 8'd1}, lastData);
        axiWrite(burstPkg::STEP, 32'd1);
        axiWrite(burstPkg::CTRL, 32'h1);        // Ignored while the burst runs
        waitBurstEnd();
        checkStatus();
        axiRead(burstPkg::STEP);
        checkValue("STEP", 32'd1, lastData);
        endTest("step latching and ignored start");

        // Five bursts with zero width first
        errAtStart = errCount;
        for (int i = 0; i < 5; i++) begin
            if (i == 0) begin
                width = 0;
            end else begin
                lcgState = lcgNext(lcgState);
                width    = int'(lcgState[19:16]);   // 0 to 15
            end
            startBurst(width);
            waitBurstEnd();
            checkStatus();
        end
        endTest("random steps");

        // Offset 0xC is unmapped
        errAtStart = errCount;
        axiWrite(4'hC, 32'h1);
        checkValue("bresp 0xC", burstPkg::RESP_SLVERR, lastResp);
        axiRead(4'hC);
        checkValue("rresp 0xC", burstPkg::RESP_SLVERR, lastResp);
        checkValue("rdata 0xC", 32'h0, lastData);
        checkStatus();                          // No burst so count unchanged
        endTest("unmapped access");

        $display("Tests passed: %0d, failed: %0d", testsPassed, testsFailed);
        if (testsFailed == 0 && errCount == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- verilog/axiLiteRegs.sv
// AXI4-Lite slave for the burst sequencer
// Holds STEP, decodes the CTRL start bit and reports busy and burst count

`timescale 1ns/1ps

module axiLiteRegs (
    input  logic                  clk,
    input  logic                  nrst,
    input  burstPkg::axiLiteReq_t req,
    output burstPkg::axiLiteRsp_t rsp,
    output burstPkg::seqCmd_t     cmd,
    input  burstPkg::seqStat_t    stat
);

    logic                        awreadyQ;      // Also drives wready
    logic                        bvalidQ;
    burstPkg::axiResp_t          brespQ;
    logic                        arreadyQ;
    logic                        rvalidQ;
    logic [burstPkg::DATA_W-1:0] rdataQ;
    burstPkg::axiResp_t          rrespQ;

    logic        startQ;
    logic [31:0] stepReg;
    logic [7:0]  burstCnt;                      // Wraps at 256

    logic wrAccept;
    logic wrFire;
    logic arAccept;
    logic rdFire;

    //----------------------------------------
    // Handshake control
    //----------------------------------------
    // Address and data must both be present, one write outstanding
    assign wrAccept = req.awvalid & req.wvalid & ~awreadyQ & ~bvalidQ;
    assign wrFire   = awreadyQ & req.awvalid & req.wvalid;

    // One read outstanding
    assign arAccept = req.arvalid & ~arreadyQ & ~rvalidQ;
    assign rdFire   = arreadyQ & req.arvalid;

    //----------------------------------------
    // Write channel
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!nrst) begin
            awreadyQ <= 1'b0;
            bvalidQ  <= 1'b0;
            startQ   <= 1'b0;
            stepReg  <= '0;
        end else begin
            awreadyQ <= wrAccept;               // One-cycle ready pulse
            startQ   <= 1'b0;
            if (wrFire) begin
                bvalidQ <= 1'b1;                // Response on the next cycle
                case (burstPkg::regAddr_t'(req.awaddr))
                    burstPkg::CTRL:   startQ  <= req.wdata[0];  // Lines up with bvalid
                    burstPkg::STEP:   stepReg <= req.wdata;
                    default:          ;         // STATUS is read-only
                endcase
            end else if (bvalidQ && req.bready) begin
                bvalidQ <= 1'b0;
            end
        end
    end

    // Write response code
    always_ff @(posedge clk) begin
        if (wrFire) begin
            case (burstPkg::regAddr_t'(req.awaddr))
                burstPkg::CTRL,
                burstPkg::STEP,
                burstPkg::STATUS: brespQ <= burstPkg::RESP_OKAY;
                default:          brespQ <= burstPkg::RESP_SLVERR;
            endcase
        end
    end

    //----------------------------------------
    // Read channel
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!nrst) begin
            arreadyQ <= 1'b0;
            rvalidQ  <= 1'b0;
        end else begin
            arreadyQ <= arAccept;
            if (rdFire) begin
                rvalidQ <= 1'b1;                // Data on the next cycle
            end else if (rvalidQ && req.rready) begin
                rvalidQ <= 1'b0;
            end
        end
    end

    // Read data mux, held until rready
    always_ff @(posedge clk) begin
        if (rdFire) begin
            rrespQ <= burstPkg::RESP_OKAY;
            case (burstPkg::regAddr_t'(req.araddr))
                burstPkg::CTRL:   rdataQ <= '0;     // Start bit is write-only
                burstPkg::STEP:   rdataQ <= stepReg;
                burstPkg::STATUS: rdataQ <= {16'd0, burstCnt, 7'd0, stat.busy};
                default: begin
                    rdataQ <= '0;
                    rrespQ <= burstPkg::RESP_SLVERR;
                end
            endcase
        end
    end

    //----------------------------------------
    // Completed burst counter
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!nrst) begin
            burstCnt <= '0;
        end else if (stat.done) begin
            burstCnt <= burstCnt + 8'd1;
        end
    end

    // Outputs
    assign rsp.awready = awreadyQ;
    assign rsp.wready  = awreadyQ;              // Same cycle as awready
    assign rsp.bvalid  = bvalidQ;
    assign rsp.bresp   = brespQ;
    assign rsp.arready = arreadyQ;
    assign rsp.rvalid  = rvalidQ;
    assign rsp.rdata   = rdataQ;
    assign rsp.rresp   = rrespQ;

    assign cmd.start     = startQ;
    assign cmd.stepWidth = stepReg;             // Sequencer latches it at start

endmodule

//--- verilog/burstPkg.sv
// Shared definitions for the trigger burst sequencer
// Sizes, register map, response codes, FSM states and bus structs

package burstPkg;

    //----------------------------------------
    // Sizes
    //----------------------------------------
    localparam int NUM_CH = 8;                  // Trigger channels
    localparam int ADDR_W = 4;                  // AXI byte address
    localparam int DATA_W = 32;                 // AXI data word
    localparam int IDX_W  = $clog2(NUM_CH);     // Channel index width

    //----------------------------------------
    // Register map and responses
    //----------------------------------------
    typedef enum logic [ADDR_W-1:0] {
        CTRL   = 4'h0,                          // Bit 0 requests a start
        STEP   = 4'h4,                          // Step width
        STATUS = 4'h8                           // Busy and burst count
    } regAddr_t;

    typedef enum logic [1:0] {
        RESP_OKAY   = 2'b00,
        RESP_SLVERR = 2'b10                     // Unmapped offset
    } axiResp_t;

    typedef enum logic {
        SEQ_IDLE,
        SEQ_RUN
    } seqState_t;

    //----------------------------------------
    // Bus structs
    //----------------------------------------
    typedef struct packed {
        logic              awvalid;
        logic [ADDR_W-1:0] awaddr;
        logic              wvalid;
        logic [DATA_W-1:0] wdata;               // Always a full word
        logic              bready;
        logic              arvalid;
        logic [ADDR_W-1:0] araddr;
        logic              rready;
    } axiLiteReq_t;

    typedef struct packed {
        logic              awready;
        logic              wready;
        logic              bvalid;
        axiResp_t          bresp;
        logic              arready;
        logic              rvalid;
        logic [DATA_W-1:0] rdata;
        axiResp_t          rresp;
    } axiLiteRsp_t;

    // Register block to sequencer
    typedef struct packed {
        logic        start;                     // One cycle
        logic [31:0] stepWidth;
    } seqCmd_t;

    // Sequencer to register block
    typedef struct packed {
        logic busy;
        logic done;                             // One cycle, end of burst
    } seqStat_t;

endpackage

//--- verilog/burstSequencer.sv
// Burst state machine
// Steps a channel index on each timer tick and decodes the trigger outputs

`timescale 1ns/1ps

module burstSequencer (
    input  logic                        clk,
    input  logic                        nrst,
    input  burstPkg::seqCmd_t           cmd,
    output burstPkg::seqStat_t          stat,
    output logic                        run,
    output logic                        load,
    input  logic                        tick,
    output logic [burstPkg::NUM_CH-1:0] trig
);

    burstPkg::seqState_t        state;
    logic [burstPkg::IDX_W-1:0] chIdx;          // Channel due on the next tick
    logic                       lastCh;
    logic                       burstEnd;

    assign lastCh   = (chIdx == burstPkg::IDX_W'(burstPkg::NUM_CH - 1));
    assign burstEnd = run & tick & lastCh;

    //----------------------------------------
    // State machine
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!nrst) begin
            state <= burstPkg::SEQ_IDLE;
            chIdx <= '0;
        end else begin
            case (state)
                burstPkg::SEQ_IDLE: begin
                    if (cmd.start) begin
                        state <= burstPkg::SEQ_RUN;
                        chIdx <= '0;
                    end
                end
                burstPkg::SEQ_RUN: begin
                    // Start is ignored here, only reset ends a burst early
                    if (tick) begin
                        if (lastCh) begin
                            state <= burstPkg::SEQ_IDLE;
                        end else begin
                            chIdx <= chIdx + burstPkg::IDX_W'(1);
                        end
                    end
                end
                default: state <= burstPkg::SEQ_IDLE;
            endcase
        end
    end

    // Timer control
    assign run  = (state == burstPkg::SEQ_RUN);
    assign load = (state == burstPkg::SEQ_IDLE) & cmd.start;   // Width latched with busy rise

    //----------------------------------------
    // Channel decode
    //----------------------------------------
    always_comb begin
        for (int k = 0; k < burstPkg::NUM_CH; k++) begin
            trig[k] = run & tick & (chIdx == burstPkg::IDX_W'(k));
        end
    end

    // Status back to the registers
    assign stat.busy = run;
    assign stat.done = burstEnd;                // Same cycle as the last pulse

endmodule

//--- verilog/stepTimer.sv
// Repeating interval timer
// One-cycle tick every stepWidth+1 cycles while run is high

`timescale 1ns/1ps

module stepTimer (
    input  logic        clk,
    input  logic        nrst,
    input  logic        run,
    input  logic        load,
    input  logic [31:0] stepWidth,
    output logic        tick
);

    logic [31:0] widthQ;                        // Width for the current burst
    logic [31:0] cnt;
    logic        tickQ;
    logic        atEnd;

    assign atEnd = (cnt == widthQ);

    //----------------------------------------
    // Width latch
    //----------------------------------------
    // Later STEP writes do not reach a running burst
    always_ff @(posedge clk) begin
        if (load) begin
            widthQ <= stepWidth;
        end
    end

    //----------------------------------------
    // Counter and tick
    //----------------------------------------
    always_ff @(posedge clk) begin
        if (!nrst) begin
            cnt   <= '0;
            tickQ <= 1'b0;
        end else if (load || !run) begin
            cnt   <= '0;                        // Held at zero while idle
            tickQ <= 1'b0;
        end else begin
            tickQ <= atEnd;                     // Registered, so first tick lands at W+1
            if (atEnd) begin
                cnt <= '0;
            end else begin
                cnt <= cnt + 32'd1;
            end
        end
    end

    // Drop a tick left over from the last cycle of a burst
    assign tick = tickQ & run;

endmodule

//--- verilog/triggerBurstTop.sv
// Trigger burst sequencer top level
// AXI4-Lite register block driving the burst FSM and its step timer

`timescale 1ns/1ps

module triggerBurstTop (
    input  logic                        clk,
    input  logic                        nrst,
    input  burstPkg::axiLiteReq_t       req,
    output burstPkg::axiLiteRsp_t       rsp,
    output logic [burstPkg::NUM_CH-1:0] trig
);

    //----------------------------------------
    // Internal wiring
    //----------------------------------------
    burstPkg::seqCmd_t  seqCmd;                 // Start and step width
    burstPkg::seqStat_t seqStat;                // Busy and done
    logic               timerRun;
    logic               timerLoad;
    logic               timerTick;

    // Control port
    axiLiteRegs regs_i (
        .clk  (clk),
        .nrst (nrst),
        .req  (req),
        .rsp  (rsp),
        .cmd  (seqCmd),
        .stat (seqStat)
    );

    // Burst FSM and channel decode
    burstSequencer seq_i (
        .clk  (clk),
        .nrst (nrst),
        .cmd  (seqCmd),
        .stat (seqStat),
        .run  (timerRun),
        .load (timerLoad),
        .tick (timerTick),
        .trig (trig)
    );

    // Pulse spacing
    stepTimer timer_i (
        .clk       (clk),
        .nrst      (nrst),
        .run       (timerRun),
        .load      (timerLoad),
        .stepWidth (seqCmd.stepWidth),
        .tick      (timerTick)
    );

endmodule
